/* compile.f */
+incdir+include
hw/dma_pkg.sv
hw/dma_regs.sv
hw/dma_reader.sv
hw/dma_fifo.sv
hw/dma_writer.sv
hw/dma_mem_router.sv
hw/dma_top.sv
testbench/dma_sva.sv
testbench/tb_dma.sv

/* hw/dma_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_fifo
    import dma_pkg::*;
#(
    parameter int DEPTH = 4
)
(
    input  logic        CLK,
    input  logic        RSTN,
    input  logic        flush,
    input  logic        push,
    input  dma_word_t   push_data,
    input  logic        pop,
    output dma_word_t   pop_data,
    output logic        full,
    output logic        empty
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

dma_word_t          mem [DEPTH];
logic [PTR_W-1:0]   wr_ptr;
logic [PTR_W-1:0]   rd_ptr;
logic [CNT_W-1:0]   count;
logic               do_push;
logic               do_pop;

assign full     = (count == CNT_W'(DEPTH));
assign empty    = (count == '0);
assign do_push  = push && !full;
assign do_pop   = pop && !empty;
assign pop_data = mem[rd_ptr];     // show-ahead

always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else if (flush) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
end

always_ff @(posedge CLK) begin
    if (do_push)
        mem[wr_ptr] <= push_data;
end

endmodule

`default_nettype wire

/* hw/dma_mem_router.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dma_defines.svh"

module dma_mem_router
    import dma_pkg::*;
(
    input  logic        CLK,
    input  logic        RSTN,
    input  dma_cfg_t    cfg,
    input  mem_req_t    rd_req,
    input  mem_req_t    wr_req,
    input  dma_word_t   mem0_rdata,
    input  dma_word_t   mem1_rdata,
    output mem_req_t    mem0_req,
    output mem_req_t    mem1_req,
    output dma_word_t   rdata
);

logic rd_bank_q;    // bank of the outstanding read

// phases never overlap, so at most one request per memory
always_comb begin
    mem0_req = '0;
    mem1_req = '0;
    if (rd_req.en) begin
        if (cfg.src[`DMA_BANK_BIT])
            mem0_req = rd_req;
        else
            mem1_req = rd_req;
    end
    if (wr_req.en) begin
        if (cfg.dst[`DMA_BANK_BIT])
            mem0_req = wr_req;
        else
            mem1_req = wr_req;
    end
end

always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN)
        rd_bank_q <= 1'b0;
    else if (rd_req.en)
        rd_bank_q <= cfg.src[`DMA_BANK_BIT];
end

assign rdata = rd_bank_q ? mem0_rdata : mem1_rdata;

endmodule

`default_nettype wire

/* hw/dma_pkg.sv */
`default_nettype none

package dma_pkg;

`include "dma_defines.svh"

    typedef logic [`DMA_DATA_W-1:0] dma_word_t;

    // programmed transfer, held by the register block
    typedef struct packed {
        logic [`DMA_ADDR_W-1:0] src;
        logic [`DMA_ADDR_W-1:0] dst;
        logic [`DMA_ADDR_W-1:0] size;
    } dma_cfg_t;

    typedef struct packed {
        logic                       en;
        logic [3:0]                 we;     // byte enables, all zero for a read
        logic [`DMA_MEM_ADDR_W-1:0] addr;
        dma_word_t                  wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_READ,
        PH_WRITE,
        PH_DONE
    } dma_phase_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ISSUE,
        RD_DRAIN
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_WRITE,
        WR_DONE
    } wr_state_e;

endpackage

`default_nettype wire

/* hw/dma_reader.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dma_defines.svh"

module dma_reader
    import dma_pkg::*;
(
    input  logic        CLK,
    input  logic        RSTN,
    input  dma_cfg_t    cfg,
    input  logic        start,
    input  dma_word_t   rdata,
    output mem_req_t    req,
    output logic        push,
    output dma_word_t   push_data,
    output logic        rd_done
);

localparam int CNT_W = 8;

rd_state_e                  state;
dma_phase_e                 phase;
logic [`DMA_MEM_ADDR_W-1:0] addr_q;
logic [CNT_W-1:0]           idx_q;
logic [CNT_W-1:0]           rd_words;
logic [`DMA_ADDR_W-1:0]     src_end;
logic [1:0]                 src_last;
logic                       vld_q;      // rdata valid this cycle
logic                       first_q;
logic                       last_q;
logic [23:0]                buf_q;      // leftover bytes, low cnt_q valid
logic [2:0]                 cnt_q;
logic [2:0]                 lo;
logic [2:0]                 hi;
logic [2:0]                 nvalid;
logic [3:0]                 total;
logic [63:0]                shifted;
logic [63:0]                merged;

// source span in words
assign src_end  = cfg.size + {{(`DMA_ADDR_W-2){1'b0}}, cfg.src[1:0]} + 3;
assign rd_words = src_end[CNT_W+1:2];
assign src_last = cfg.src[1:0] + cfg.size[1:0] - 2'd1;

assign req = '{en: (state == RD_ISSUE), we: 4'b0000, addr: addr_q, wdata: '0};

always_comb begin
    case (state)
        RD_ISSUE: phase = PH_READ;
        RD_DRAIN: phase = vld_q ? PH_READ : PH_DONE;   // wait for last word
        default:  phase = PH_IDLE;
    endcase
end

assign rd_done = (phase == PH_DONE);

////////////////////
// byte realign
////////////////////
always_comb begin
    lo      = first_q ? {1'b0, cfg.src[1:0]} : 3'd0;
    hi      = last_q ? {1'b0, src_last} + 3'd1 : 3'd4;
    nvalid  = hi - lo;
    shifted = ({32'b0, rdata} >> (8 * lo)) & ~(64'hFFFF_FFFF_FFFF_FFFF << (8 * nvalid));
    merged  = {40'b0, buf_q} | (shifted << (8 * cnt_q));
    total   = {1'b0, cnt_q} + {1'b0, nvalid};
end

always_comb begin
    push      = 1'b0;
    push_data = merged[31:0];
    if (vld_q && (total >= 4'd4)) begin
        push = 1'b1;
    end else if (phase == PH_DONE && cnt_q != 3'd0) begin
        push      = 1'b1;   // partial tail word
        push_data = {8'b0, buf_q};
    end
end

always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
        state   <= RD_IDLE;
        idx_q   <= '0;
        vld_q   <= 1'b0;
        first_q <= 1'b0;
        last_q  <= 1'b0;
        cnt_q   <= '0;
    end else begin
        vld_q   <= (state == RD_ISSUE);
        first_q <= (idx_q == '0);
        last_q  <= (idx_q == rd_words - 1'b1);
        case (state)
            RD_IDLE: begin
                if (start) begin
                    state <= RD_ISSUE;
                    idx_q <= '0;
                    cnt_q <= {1'b0, cfg.dst[1:0]};  // pad up to dst offset
                end
            end
            RD_ISSUE: begin
                idx_q <= idx_q + 1'b1;
                if (idx_q == rd_words - 1'b1)
                    state <= RD_DRAIN;
            end
            default: begin
                if (!vld_q)
                    state <= RD_IDLE;
            end
        endcase
        if (vld_q)
            cnt_q <= (total >= 4'd4) ? 3'(total - 4'd4) : total[2:0];
    end
end

always_ff @(posedge CLK) begin
    if (state == RD_IDLE && start) begin
        addr_q <= cfg.src[`DMA_MEM_ADDR_W+1:2];
        buf_q  <= '0;
    end else begin
        if (state == RD_ISSUE)
            addr_q <= addr_q + 1'b1;
        if (vld_q)
            buf_q <= (total >= 4'd4) ? merged[55:32] : merged[23:0];
    end
end

endmodule

`default_nettype wire

/* hw/dma_regs.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dma_defines.svh"

module dma_regs
    import dma_pkg::*;
(
    input  logic                    CLK,
    input  logic                    RSTN,
    input  logic                    PSEL,
    input  logic                    PENABLE,
    input  logic                    PWRITE,
    input  logic [`DMA_ADDR_W-1:0]  PADDR,
    input  logic [`DMA_DATA_W-1:0]  PWDATA,
    input  logic                    done,
    output logic [`DMA_DATA_W-1:0]  PRDATA,
    output logic                    PREADY,
    output dma_cfg_t                cfg,
    output logic                    start,
    output logic                    INTR
);

logic                   access;
logic                   wr_acc;
logic                   go;
logic                   size_bad;
logic                   clr_done;
logic                   busy;
logic                   done_q;
logic [`DMA_ADDR_W-1:0] src_q;
logic [`DMA_ADDR_W-1:0] dst_q;
logic [`DMA_ADDR_W-1:0] size_q;
logic [`DMA_DATA_W-1:0] rd_mux;

assign access   = PSEL && PENABLE && !PREADY;     // one take per access
assign wr_acc   = access && PWRITE;
assign size_bad = (size_q == '0) || (size_q > `DMA_MAX_BYTES);
assign go       = wr_acc && (PADDR == `DMA_REG_CTRL) && PWDATA[0] && !busy;
assign clr_done = wr_acc && (PADDR == `DMA_REG_STATUS) && PWDATA[0];

assign cfg  = '{src: src_q, dst: dst_q, size: size_q};
assign INTR = done_q;

////////////////////
// register writes
////////////////////
always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
        PREADY <= 1'b0;
        start  <= 1'b0;
        busy   <= 1'b0;
        done_q <= 1'b0;
        src_q  <= '0;
        dst_q  <= '0;
        size_q <= '0;
    end else begin
        PREADY <= access;
        start  <= go && !size_bad;

        if (go && !size_bad)
            busy <= 1'b1;
        else if (done)
            busy <= 1'b0;

        // bad size finishes right away, no transfer
        if (done || (go && size_bad))
            done_q <= 1'b1;
        else if (clr_done)
            done_q <= 1'b0;

        if (wr_acc) begin
            case (PADDR)
                `DMA_REG_SRC:  src_q  <= PWDATA;
                `DMA_REG_DST:  dst_q  <= PWDATA;
                `DMA_REG_SIZE: size_q <= PWDATA;
                default: ;
            endcase
        end
    end
end

////////////////////
// read data
////////////////////
always_comb begin
    case (PADDR)
        `DMA_REG_SRC:    rd_mux = src_q;
        `DMA_REG_DST:    rd_mux = dst_q;
        `DMA_REG_SIZE:   rd_mux = size_q;
        `DMA_REG_CTRL:   rd_mux = {{(`DMA_DATA_W-1){1'b0}}, busy};
        `DMA_REG_STATUS: rd_mux = {{(`DMA_DATA_W-1){1'b0}}, done_q};
        default:         rd_mux = '0;     // unmapped
    endcase
end

always_ff @(posedge CLK) begin
    if (access && !PWRITE)
        PRDATA <= rd_mux;
end

endmodule

`default_nettype wire

/* hw/dma_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dma_defines.svh"

module dma_top
    import dma_pkg::*;
(
    input  logic                    CLK,
    input  logic                    RSTN,
    output logic                    INTR,
    // apb
    input  logic                    PSEL,
    input  logic                    PENABLE,
    input  logic                    PWRITE,
    input  logic [`DMA_ADDR_W-1:0]  PADDR,
    input  logic [`DMA_DATA_W-1:0]  PWDATA,
    output logic [`DMA_DATA_W-1:0]  PRDATA,
    output logic                    PREADY,
    // memories
    output mem_req_t                mem0_req,
    input  dma_word_t               mem0_rdata,
    output mem_req_t                mem1_req,
    input  dma_word_t               mem1_rdata
);

dma_cfg_t   cfg;
logic       start;
logic       done;
logic       rd_done;
mem_req_t   rd_req;
mem_req_t   wr_req;
dma_word_t  rdata;
logic       push;
dma_word_t  push_data;
logic       pop;
dma_word_t  pop_data;
logic       fifo_full;

dma_regs u_regs (
    .CLK     (CLK),
    .RSTN    (RSTN),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .done    (done),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY),
    .cfg     (cfg),
    .start   (start),
    .INTR    (INTR)
);

dma_reader u_reader (
    .CLK       (CLK),
    .RSTN      (RSTN),
    .cfg       (cfg),
    .start     (start),
    .rdata     (rdata),
    .req       (rd_req),
    .push      (push),
    .push_data (push_data),
    .rd_done   (rd_done)
);

dma_fifo #(.DEPTH(`DMA_FIFO_DEPTH)) u_fifo (
    .CLK       (CLK),
    .RSTN      (RSTN),
    .flush     (start),     // new transfer starts empty
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (fifo_full),
    .empty     ()
);

dma_writer u_writer (
    .CLK      (CLK),
    .RSTN     (RSTN),
    .cfg      (cfg),
    .rd_done  (rd_done),
    .pop_data (pop_data),
    .req      (wr_req),
    .pop      (pop),
    .done     (done)
);

dma_mem_router u_router (
    .CLK        (CLK),
    .RSTN       (RSTN),
    .cfg        (cfg),
    .rd_req     (rd_req),
    .wr_req     (wr_req),
    .mem0_rdata (mem0_rdata),
    .mem1_rdata (mem1_rdata),
    .mem0_req   (mem0_req),
    .mem1_req   (mem1_req),
    .rdata      (rdata)
);

endmodule

`default_nettype wire

/* hw/dma_writer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dma_defines.svh"

module dma_writer
    import dma_pkg::*;
(
    input  logic        CLK,
    input  logic        RSTN,
    input  dma_cfg_t    cfg,
    input  logic        rd_done,
    input  dma_word_t   pop_data,
    output mem_req_t    req,
    output logic        pop,
    output logic        done
);

localparam int CNT_W = 8;

wr_state_e                  state;
dma_phase_e                 phase;
logic [`DMA_MEM_ADDR_W-1:0] addr_q;
logic [CNT_W-1:0]           idx_q;
logic [CNT_W-1:0]           wr_words;
logic [`DMA_ADDR_W-1:0]     dst_end;
logic [1:0]                 dst_last;   // offset of the end byte
logic [3:0]                 first_be;
logic [3:0]                 last_be;
logic [3:0]                 be;
logic                       is_first;
logic                       is_last;

// destination span in words
assign dst_end  = cfg.size + {{(`DMA_ADDR_W-2){1'b0}}, cfg.dst[1:0]} + 3;
assign wr_words = dst_end[CNT_W+1:2];
assign dst_last = cfg.dst[1:0] + cfg.size[1:0] - 2'd1;

assign first_be = 4'b1111 << cfg.dst[1:0];
assign last_be  = 4'b1111 >> (2'd3 - dst_last);
assign is_first = (idx_q == '0);
assign is_last  = (idx_q == wr_words - 1'b1);
assign be       = (is_first ? first_be : 4'b1111) & (is_last ? last_be : 4'b1111);

always_comb begin
    case (state)
        WR_WRITE: phase = PH_WRITE;
        WR_DONE:  phase = PH_DONE;
        default:  phase = PH_IDLE;
    endcase
end

assign pop  = (phase == PH_WRITE);
assign done = (phase == PH_DONE);
assign req  = '{en: pop, we: pop ? be : 4'b0000, addr: addr_q, wdata: pop_data};

////////////////////
// write sequencer
////////////////////
always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
        state <= WR_IDLE;
        idx_q <= '0;
    end else begin
        case (state)
            WR_IDLE: begin
                if (rd_done) begin
                    state <= WR_WRITE;
                    idx_q <= '0;
                end
            end
            WR_WRITE: begin
                idx_q <= idx_q + 1'b1;
                if (is_last)
                    state <= WR_DONE;
            end
            default: state <= WR_IDLE;
        endcase
    end
end

always_ff @(posedge CLK) begin
    if (state == WR_IDLE && rd_done)
        addr_q <= cfg.dst[`DMA_MEM_ADDR_W+1:2];
    else if (state == WR_WRITE)
        addr_q <= addr_q + 1'b1;
end

endmodule

`default_nettype wire

/* include/dma_defines.svh */
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// bus widths
`define DMA_ADDR_W          32
`define DMA_DATA_W          32

// memory word address from byte address bits 17..2
`define DMA_MEM_ADDR_W      16
`define DMA_BANK_BIT        20      // set -> mem0, clear -> mem1

// register map
`define DMA_REG_SRC         32'h0000_0000
`define DMA_REG_DST         32'h0000_0004
`define DMA_REG_SIZE        32'h0000_0008
`define DMA_REG_CTRL        32'h0000_000C
`define DMA_REG_STATUS      32'h0000_0010

// transfer limit, fifo holds a whole transfer plus offset
`define DMA_MAX_BYTES       64
`define DMA_FIFO_DEPTH      17

`endif

/* run.sh */
#!/usr/bin/env bash
# build and run tb_dma with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_dma -o sim_tb_dma \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_tb_dma > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

/* testbench/dma_sva.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dma_defines.svh"

module dma_sva
    import dma_pkg::*;
(
    input logic                     CLK,
    input logic                     RSTN,
    input logic                     PSEL,
    input logic                     PENABLE,
    input logic                     PWRITE,
    input logic [`DMA_ADDR_W-1:0]   PADDR,
    input logic [`DMA_DATA_W-1:0]   PWDATA,
    input logic                     PREADY,
    input logic                     INTR,
    input mem_req_t                 mem0_req,
    input mem_req_t                 mem1_req,
    input logic                     push,
    input logic                     fifo_full
);

logic status_clr;

assign status_clr = PSEL && PENABLE && !PREADY && PWRITE
                    && (PADDR == `DMA_REG_STATUS) && PWDATA[0];

a_pready_pulse: assert property (@(posedge CLK) disable iff (!RSTN)
    PREADY |=> !PREADY) else $error("PREADY high for more than one cycle");

a_one_mem_write: assert property (@(posedge CLK) disable iff (!RSTN)
    !((|mem0_req.we) && (|mem1_req.we))) else $error("both memories written together");

a_we_mem0: assert property (@(posedge CLK) disable iff (!RSTN)
    (|mem0_req.we) |-> mem0_req.en) else $error("mem0 write enable without enable");

a_we_mem1: assert property (@(posedge CLK) disable iff (!RSTN)
    (|mem1_req.we) |-> mem1_req.en) else $error("mem1 write enable without enable");

a_no_push_full: assert property (@(posedge CLK) disable iff (!RSTN)
    push |-> !fifo_full) else $error("fifo pushed while full");

// done flag only clears from software
a_intr_fall: assert property (@(posedge CLK) disable iff (!RSTN)
    $fell(INTR) |-> $past(status_clr)) else $error("INTR fell without a STATUS write");

endmodule

bind dma_top dma_sva u_dma_sva (
    .CLK       (CLK),
    .RSTN      (RSTN),
    .PSEL      (PSEL),
    .PENABLE   (PENABLE),
    .PWRITE    (PWRITE),
    .PADDR     (PADDR),
    .PWDATA    (PWDATA),
    .PREADY    (PREADY),
    .INTR      (INTR),
    .mem0_req  (mem0_req),
    .mem1_req  (mem1_req),
    .push      (push),
    .fifo_full (fifo_full)
);

`default_nettype wire

/* testbench/tb_dma.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dma_defines.svh"

module tb_dma
    import dma_pkg::*;
();

localparam int          RESET_CYCLES = 5;
localparam int          NUM_TESTS    = 52;
localparam int          TIMEOUT      = NUM_TESTS * 200 + RESET_CYCLES;
localparam logic [31:0] SEED         = 32'h13f5_b3b8;
localparam int          MEM_WORDS    = 1 << `DMA_MEM_ADDR_W;

typedef struct {
    string       name;
    logic [31:0] src;
    logic [31:0] dst;
    logic [31:0] size;
    logic        moves;     // destination expected to change
} test_t;

logic                   CLK = 1'b0;
logic                   RSTN;
logic                   PSEL;
logic                   PENABLE;
logic                   PWRITE;
logic [`DMA_ADDR_W-1:0] PADDR;
logic [`DMA_DATA_W-1:0] PWDATA;
logic [`DMA_DATA_W-1:0] PRDATA;
logic                   PREADY;
logic                   INTR;
mem_req_t               mem0_req;
mem_req_t               mem1_req;
dma_word_t              mem0_rdata = '0;
dma_word_t              mem1_rdata = '0;

dma_word_t              mem0 [MEM_WORDS];
dma_word_t              mem1 [MEM_WORDS];
logic                   filled = 1'b0;
test_t                  tests [NUM_TESTS];
int                     errors = 0;
int                     checks = 0;
int                     cycles = 0;

always #4 CLK = ~CLK;

dma_top u_dma_top (
    .CLK        (CLK),
    .RSTN       (RSTN),
    .INTR       (INTR),
    .PSEL       (PSEL),
    .PENABLE    (PENABLE),
    .PWRITE     (PWRITE),
    .PADDR      (PADDR),
    .PWDATA     (PWDATA),
    .PRDATA     (PRDATA),
    .PREADY     (PREADY),
    .mem0_req   (mem0_req),
    .mem0_rdata (mem0_rdata),
    .mem1_req   (mem1_req),
    .mem1_rdata (mem1_rdata)
);

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic dma_word_t fill_word(input logic bank0, input logic [15:0] a);
    return lcg_next(lcg_next(SEED ^ {15'b0, bank0, a}));
endfunction

////////////////////
// memory models
////////////////////
always @(posedge CLK) begin
    if (!filled) begin
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem0[a] <= fill_word(1'b1, a[15:0]);
            mem1[a] <= fill_word(1'b0, a[15:0]);
        end
        filled <= 1'b1;
    end else begin
        if (mem0_req.en) begin
            for (int b = 0; b < 4; b++)
                if (mem0_req.we[b])
                    mem0[mem0_req.addr][8*b +: 8] <= mem0_req.wdata[8*b +: 8];
            mem0_rdata <= mem0[mem0_req.addr];
        end
        if (mem1_req.en) begin
            for (int b = 0; b < 4; b++)
                if (mem1_req.we[b])
                    mem1[mem1_req.addr][8*b +: 8] <= mem1_req.wdata[8*b +: 8];
            mem1_rdata <= mem1[mem1_req.addr];
        end
    end
end

always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
        $display("timeout: run still going after %0d cycles", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end
end

function automatic dma_word_t mem_word(input logic bank0, input int w);
    logic [15:0] idx;
    idx = w[15:0];
    return bank0 ? mem0[idx] : mem1[idx];
endfunction

function automatic logic [7:0] mem_byte(input logic bank0, input int a);
    dma_word_t w;
    w = mem_word(bank0, a / 4);
    return w[8*a[1:0] +: 8];
endfunction

task automatic check_word(input string what, input dma_word_t exp, input dma_word_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s expected %08h actual %08h", what, exp, act);
    end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s expected %0b actual %0b", what, exp, act);
    end
endtask

////////////////////
// apb master
////////////////////
task automatic apb_access(input logic wr, input logic [31:0] addr, input dma_word_t wdata,
                          output dma_word_t rdata);
    @(posedge CLK);
    #1;
    PSEL   = 1'b1;
    PWRITE = wr;
    PADDR  = addr;
    PWDATA = wdata;
    @(posedge CLK);
    #1;
    PENABLE = 1'b1;
    do begin
        @(posedge CLK);
        #1;
    end while (!PREADY);
    rdata = PRDATA;
    @(posedge CLK);     // transfer completes on this edge
    #1;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
endtask

task automatic apb_write(input logic [31:0] addr, input dma_word_t data);
    dma_word_t unused;
    apb_access(1'b1, addr, data, unused);
endtask

task automatic apb_read(input logic [31:0] addr, output dma_word_t data);
    apb_access(1'b0, addr, '0, data);
endtask

task automatic build_table();
    int          k;
    int          sizes [3];
    logic [31:0] src;
    logic [31:0] dst;
    sizes = '{1, 5, 13};
    tests[0] = '{"aligned_m0_to_m1", 32'h0010_0400, 32'h0000_0800, 32'd16, 1'b1};
    tests[1] = '{"aligned_m1_to_m0", 32'h0000_0c00, 32'h0010_1000, 32'd64, 1'b1};
    for (int so = 0; so < 4; so++) begin
        for (int dof = 0; dof < 4; dof++) begin
            for (int z = 0; z < 3; z++) begin
                k   = 2 + so * 12 + dof * 3 + z;
                src = (k % 2 == 0) ? 32'h0010_0400 : 32'h0000_0c00;   // alternate direction
                dst = (k % 2 == 0) ? 32'h0000_0800 : 32'h0010_1000;
                tests[k] = '{$sformatf("misalign_s%0d_d%0d_n%0d", so, dof, sizes[z]),
                             src + 32'(so), dst + 32'(dof), 32'(sizes[z]), 1'b1};
            end
        end
    end
    tests[50] = '{"size_zero", 32'h0010_0401, 32'h0000_0802, 32'd0, 1'b0};
    tests[51] = '{"size_over", 32'h0000_0c00, 32'h0010_1003, 32'(`DMA_MAX_BYTES + 1), 1'b0};
endtask

task automatic check_regs();
    dma_word_t rd;
    apb_write(`DMA_REG_SRC, 32'h0010_1234);
    apb_write(`DMA_REG_DST, 32'h0000_5678);
    apb_write(`DMA_REG_SIZE, 32'h0000_002a);
    apb_write(32'h0000_0020, 32'hdead_beef);    // unmapped
    apb_read(`DMA_REG_SRC, rd);
    check_word("regs src", 32'h0010_1234, rd);
    apb_read(`DMA_REG_DST, rd);
    check_word("regs dst", 32'h0000_5678, rd);
    apb_read(`DMA_REG_SIZE, rd);
    check_word("regs size", 32'h0000_002a, rd);
    apb_read(32'h0000_0020, rd);
    check_word("regs unmapped", '0, rd);
    apb_read(`DMA_REG_CTRL, rd);
    check_bit("regs idle busy", 1'b0, rd[0]);
    check_bit("regs idle intr", 1'b0, INTR);
endtask

task automatic run_test(input test_t t);
    dma_word_t exp_q [$];
    dma_word_t word;
    dma_word_t rd;
    int        d;
    int        s;
    int        n;
    int        a;
    int        first_w;
    int        last_w;
    d = int'(t.dst[17:0]);
    s = int'(t.src[17:0]);
    n = int'(t.size);
    // one guard word on each side of the destination
    first_w = d / 4 - 1;
    last_w  = (d + ((n == 0) ? 1 : n) - 1) / 4 + 1;
    for (int w = first_w; w <= last_w; w++) begin
        word = mem_word(t.dst[`DMA_BANK_BIT], w);
        for (int b = 0; b < 4; b++) begin
            a = 4 * w + b;
            if (t.moves && a >= d && a < d + n)
                word[8*b +: 8] = mem_byte(t.src[`DMA_BANK_BIT], s + a - d);
        end
        exp_q.push_back(word);
    end

    apb_write(`DMA_REG_SRC, t.src);
    apb_write(`DMA_REG_DST, t.dst);
    apb_write(`DMA_REG_SIZE, t.size);
    apb_write(`DMA_REG_CTRL, 32'h1);
    if (t.moves) begin
        apb_read(`DMA_REG_CTRL, rd);
        check_bit({t.name, " busy"}, 1'b1, rd[0]);
    end
    while (!INTR) begin
        @(posedge CLK);
        #1;
    end
    apb_read(`DMA_REG_CTRL, rd);
    check_bit({t.name, " busy after intr"}, 1'b0, rd[0]);
    apb_read(`DMA_REG_STATUS, rd);
    check_word({t.name, " status"}, 32'h1, rd);
    foreach (exp_q[i])
        check_word($sformatf("%s word %0h", t.name, first_w + i), exp_q[i],
                   mem_word(t.dst[`DMA_BANK_BIT], first_w + i));
    apb_write(`DMA_REG_STATUS, 32'h1);
    check_bit({t.name, " intr cleared"}, 1'b0, INTR);
endtask

////////////////////
// main sequence
////////////////////
initial begin
    RSTN    = 1'b0;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    build_table();
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    RSTN = 1'b1;
    check_regs();
    for (int k = 0; k < NUM_TESTS; k++)
        run_test(tests[k]);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
        $display("TESTBENCH PASSED");
    else
        $display("TESTBENCH FAILED");
    $finish;
end

endmodule

`default_nettype wire
